//--- common/cache_pkg.sv
// shared cache geometry, address split helpers and controller states, imported by every cache block
`default_nettype none

package cache_pkg;

	// bus widths
	localparam int ADDR_W = 16;   // byte address
	localparam int WORD_W = 16;   // one bus word

	// address split, bit 0 never used since the bus is word wide
	localparam int TAG_W    = 5;  // addr[15:11]
	localparam int INDEX_W  = 7;  // addr[10:4]
	localparam int OFFSET_W = 3;  // addr[3:1]

	localparam int NUM_BLOCKS      = 1 << INDEX_W;   // 128 blocks, direct mapped
	localparam int WORDS_PER_BLOCK = 1 << OFFSET_W;  // 8 words per block

	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	// controller states
	typedef enum logic [2:0] {
		IDLE,       // waiting for a cpu request
		LOOKUP,     // tag compare on the registered address
		MEM_WRITE,  // write-through to memory
		FILL_REQ,   // issue one word read of the block
		FILL_WAIT,  // wait for that word to come back
		FILL_DONE   // mark block valid with new tag
	} ctrl_state_t;

	// top bits of the address
	function automatic tag_t addr_tag(input addr_t addr);
		return addr[ADDR_W-1 -: TAG_W];
	endfunction

	// block select, sits right above the word offset
	function automatic index_t addr_index(input addr_t addr);
		return addr[OFFSET_W+1 +: INDEX_W];
	endfunction

	// word within block, skips the byte bit
	function automatic offset_t addr_offset(input addr_t addr);
		return addr[1 +: OFFSET_W];
	endfunction

endpackage

`default_nettype wire

//--- common/cache_array_if.sv
// bundle between the cache controller and the tag and data arrays, one modport per side
`default_nettype none
`timescale 1ns/100ps

interface cache_array_if;
	import cache_pkg::*;

	// driven by the controller
	index_t  index;       // block being looked up or filled
	offset_t offset;      // word inside that block
	tag_t    tag;         // tag to compare, also the tag stored on fill
	logic    tag_write;   // store tag and set valid at this edge
	logic    data_write;  // store wdata at index/offset at this edge
	word_t   wdata;       // fill word or cpu write word

	// driven by the arrays
	logic    hit;         // from tag array
	word_t   rdata;       // from data array, combinational read

	modport ctrl (
		output index,
		output offset,
		output tag,
		output tag_write,
		output data_write,
		output wdata,
		input  hit,
		input  rdata
	);

	// each array drives only its own result
	modport array (
		input  index,
		input  offset,
		input  tag,
		input  tag_write,
		input  data_write,
		input  wdata,
		output hit,
		output rdata
	);

endinterface

`default_nettype wire

//--- cache/cache_tag_array.sv
// valid bits and tags for all cache blocks, reports a hit for the index and tag on the array bus
`default_nettype none
`timescale 1ns/100ps

module cache_tag_array (
	input  logic          clk,
	input  logic          rst_n,
	cache_array_if.array  arr
);
	import cache_pkg::*;

	logic [NUM_BLOCKS-1:0] valid;        // one bit per block
	tag_t                  tags [NUM_BLOCKS];  // tag of resident block

	tag_t                  stored_tag;   // tag at current index
	logic                  stored_vld;   // valid at current index

	// valid bits need clearing so cold blocks miss
	always_ff @(posedge clk) begin
		if (!rst_n)
			valid <= '0;
		else if (arr.tag_write)
			valid[arr.index] <= 1'b1;  // only ever set, a block is replaced not dropped
	end

	// tag storage, contents meaningless until valid is set
	always_ff @(posedge clk) begin
		if (arr.tag_write)
			tags[arr.index] <= arr.tag;
	end

	assign stored_tag = tags[arr.index];
	assign stored_vld = valid[arr.index];

	// hit only when block is resident and tags agree
	assign arr.hit = stored_vld && (stored_tag == arr.tag);

	// tag is stored after the last fill word, never with a data write
	a_tag_data_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(arr.tag_write && arr.data_write));

endmodule

`default_nettype wire

//--- cache/cache_data_array.sv
// word storage for all cache blocks, combinational read and single word write at index and offset
`default_nettype none
`timescale 1ns/100ps

module cache_data_array (
	input  logic          clk,
	cache_array_if.array  arr
);
	import cache_pkg::*;

	localparam int DEPTH = NUM_BLOCKS * WORDS_PER_BLOCK;  // 1024 words

	word_t mem [DEPTH];  // block-major, index then offset

	logic [INDEX_W+OFFSET_W-1:0] word_addr;  // flat word location

	assign word_addr = {arr.index, arr.offset};

	// read follows index/offset in the same cycle
	assign arr.rdata = mem[word_addr];

	// one word per edge, fill word or write-through word
	always_ff @(posedge clk) begin
		if (arr.data_write)
			mem[word_addr] <= arr.wdata;
	end

endmodule

`default_nettype wire

//--- cache/cache_ctrl.sv
// cache controller FSM, takes one cpu request at a time and does lookup, write-through and block fill
`default_nettype none
`timescale 1ns/100ps

module cache_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	// cpu request
	input  logic             cpu_valid,
	output logic             cpu_ready,
	input  logic             cpu_write,
	input  cache_pkg::addr_t cpu_addr,
	input  cache_pkg::word_t cpu_wdata,
	// cpu response, single cycle pulse
	output logic             resp_valid,
	output cache_pkg::word_t resp_data,
	// memory request
	output logic             mem_req_valid,
	input  logic             mem_req_ready,
	output logic             mem_req_write,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata,
	// memory read return, in order
	input  logic             mem_rdata_valid,
	input  cache_pkg::word_t mem_rdata,
	// tag and data arrays
	cache_array_if.ctrl      arr
);
	import cache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	addr_t   req_addr;    // accepted cpu address
	word_t   req_wdata;   // accepted cpu write data
	logic    req_write;   // accepted op is a write
	logic    wr_done;     // memory took the write-through
	offset_t fill_cnt;    // next word of the block to fetch

	tag_t    req_tag;
	index_t  req_index;
	offset_t req_offset;

	logic    cpu_fire;    // request handshake
	logic    mem_fire;    // memory accepted our request
	logic    last_word;   // fill counter on final word

	assign req_tag    = addr_tag(req_addr);
	assign req_index  = addr_index(req_addr);
	assign req_offset = addr_offset(req_addr);

	assign cpu_ready = (state == IDLE);  // only one request in flight
	assign cpu_fire  = cpu_valid && cpu_ready;
	assign mem_fire  = mem_req_valid && mem_req_ready;
	assign last_word = (fill_cnt == offset_t'(WORDS_PER_BLOCK - 1));

	// request payload, held for the whole transaction
	always_ff @(posedge clk) begin
		if (cpu_fire) begin
			req_addr  <= cpu_addr;
			req_wdata <= cpu_wdata;
		end
	end

	// control state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			req_write <= 1'b0;
			wr_done   <= 1'b0;
			fill_cnt  <= '0;
		end else begin
			state <= state_nxt;
			if (cpu_fire) begin
				req_write <= cpu_write;
				wr_done   <= 1'b0;   // new request, write-through still owed
			end else if (state == MEM_WRITE && mem_fire) begin
				wr_done   <= 1'b1;
			end
			if (state == FILL_WAIT && mem_rdata_valid)
				fill_cnt <= fill_cnt + 1'b1;  // wraps back to 0 after word 7
		end
	end

	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (cpu_fire)
					state_nxt = LOOKUP;
			end
			LOOKUP: begin
				if (!arr.hit)
					state_nxt = FILL_REQ;     // read or write miss, allocate first
				else if (req_write && !wr_done)
					state_nxt = MEM_WRITE;    // write hit goes through to memory
				else
					state_nxt = IDLE;         // response goes out this cycle
			end
			MEM_WRITE: begin
				if (mem_fire)
					state_nxt = LOOKUP;       // second pass sends the write response
			end
			FILL_REQ: begin
				if (mem_fire)
					state_nxt = FILL_WAIT;
			end
			FILL_WAIT: begin
				if (mem_rdata_valid)
					state_nxt = last_word ? FILL_DONE : FILL_REQ;
			end
			FILL_DONE: state_nxt = LOOKUP;     // now hits
			default:   state_nxt = IDLE;
		endcase
	end

	// response comes straight off the lookup
	assign resp_valid = (state == LOOKUP) && arr.hit && (!req_write || wr_done);
	assign resp_data  = arr.rdata;  // only meaningful for reads

	// memory side
	assign mem_req_valid = (state == MEM_WRITE) || (state == FILL_REQ);
	assign mem_req_write = (state == MEM_WRITE);
	assign mem_addr      = (state == FILL_REQ) ? {req_tag, req_index, fill_cnt, 1'b0}
	                                           : {req_addr[15:1], 1'b0};
	assign mem_wdata     = req_wdata;

	// array side
	assign arr.index      = req_index;
	assign arr.offset     = (state == FILL_WAIT) ? fill_cnt : req_offset;
	assign arr.tag        = req_tag;
	assign arr.tag_write  = (state == FILL_DONE);
	assign arr.data_write = (state == FILL_WAIT && mem_rdata_valid)
	                     || (state == MEM_WRITE && mem_fire);  // cache and memory updated together
	assign arr.wdata      = (state == FILL_WAIT) ? mem_rdata : req_wdata;

	// memory only returns data for a read we issued
	a_rdata_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rdata_valid |-> state == FILL_WAIT);

	// response is a pulse
	a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |=> !resp_valid);

	// no new request accepted while answering the old one
	a_ready_resp: assert property (@(posedge clk) disable iff (!rst_n)
		!(cpu_ready && resp_valid));

endmodule

`default_nettype wire

//--- design/cache_top.sv
// top level of the direct-mapped write-through cache, wires controller and arrays to cpu and memory ports
`default_nettype none
`timescale 1ns/100ps

module cache_top (
	input  logic             clk,
	input  logic             rst_n,
	// cpu request
	input  logic             cpu_valid,
	input  logic             cpu_write,
	output logic             cpu_ready,
	input  cache_pkg::addr_t cpu_addr,
	input  cache_pkg::word_t cpu_wdata,
	// cpu response
	output logic             resp_valid,
	output cache_pkg::word_t resp_data,
	// memory request
	output logic             mem_req_valid,
	output logic             mem_req_write,
	input  logic             mem_req_ready,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata,
	// memory read data
	input  logic             mem_rdata_valid,
	input  cache_pkg::word_t mem_rdata
);

	cache_array_if arr_if ();  // controller to arrays

	// FSM, owns all ports
	cache_ctrl ctrl_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.cpu_valid       (cpu_valid),
		.cpu_ready       (cpu_ready),
		.cpu_write       (cpu_write),
		.cpu_addr        (cpu_addr),
		.cpu_wdata       (cpu_wdata),
		.resp_valid      (resp_valid),
		.resp_data       (resp_data),
		.mem_req_valid   (mem_req_valid),
		.mem_req_ready   (mem_req_ready),
		.mem_req_write   (mem_req_write),
		.mem_addr        (mem_addr),
		.mem_wdata       (mem_wdata),
		.mem_rdata_valid (mem_rdata_valid),
		.mem_rdata       (mem_rdata),
		.arr             (arr_if.ctrl)
	);

	// valid and tag per block, gives hit
	cache_tag_array tag_i (
		.clk   (clk),
		.rst_n (rst_n),
		.arr   (arr_if.array)
	);

	// block words, gives rdata
	cache_data_array data_i (
		.clk (clk),
		.arr (arr_if.array)
	);

endmodule

`default_nettype wire

//--- testbench/cache_tb_mem.sv
// behavioral main memory for the cache testbench, random accept back-pressure and random read latency
`default_nettype none
`timescale 1ns/100ps

module cache_tb_mem (
	input  logic             clk,
	input  logic             mem_req_valid,
	output logic             mem_req_ready,
	input  logic             mem_req_write,
	input  cache_pkg::addr_t mem_addr,
	input  cache_pkg::word_t mem_wdata,
	output logic             mem_rdata_valid,
	output cache_pkg::word_t mem_rdata
);
	import cache_pkg::*;

	localparam int MEM_WORDS = 1 << (ADDR_W - 1);  // 32K words, byte bit dropped

	word_t mem [MEM_WORDS];  // loaded by the testbench before reset ends
	int    lat_left;         // cycles until read data shows, 0 when idle
	addr_t rd_addr;          // address of the read in flight

	initial begin
		mem_req_ready   = 1'b0;
		mem_rdata_valid = 1'b0;
		mem_rdata       = '0;
		lat_left        = 0;
		rd_addr         = '0;
	end

	// everything changes on the falling edge, the cache samples on the rising one
	always @(negedge clk) begin : drive
		logic rdy;

		mem_rdata_valid = 1'b0;  // data is a one cycle pulse
		if (lat_left > 0) begin
			lat_left = lat_left - 1;
			if (lat_left == 0) begin
				mem_rdata_valid = 1'b1;
				mem_rdata       = mem[rd_addr[15:1]];
			end
		end

		rdy           = ($urandom_range(3) != 0);  // accept about three cycles in four
		mem_req_ready = rdy;

		// valid is steady until the next rising edge, so this is the transfer on that edge
		if (mem_req_valid && rdy) begin
			if (mem_req_write) begin
				mem[mem_addr[15:1]] = mem_wdata;  // write lands on acceptance
			end else begin
				rd_addr  = mem_addr;
				lat_left = 1 + int'($urandom_range(5));  // 1 to 6 cycles
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/cache_tb.sv
// self-checking cache testbench that runs directed and random cpu traffic against a shadow model
`default_nettype none
`timescale 1ns/100ps

module cache_tb;
	import cache_pkg::*;

	localparam int    CLK_PERIOD   = 10;
	localparam int    RESET_CYCLES = 16;
	localparam int    NUM_RANDOM   = 400;
	localparam int    NUM_REQS     = 27 + NUM_RANDOM;  // directed requests plus random mix
	localparam int    REQ_CYCLES   = 200;              // worst case allowed per request
	localparam int    MEM_WORDS    = 1 << (ADDR_W - 1);
	localparam addr_t ADDR_A       = 16'h0a46;  // tag 1 at index 0x24
	localparam addr_t ADDR_B       = 16'h3c1a;  // tag 7 at index 0x41
	localparam addr_t ADDR_C       = 16'h5d70;  // index 0x57
	localparam addr_t ADDR_D       = 16'hd570;  // same index as C with another tag

	logic  clk;
	logic  rst_n;
	logic  cpu_valid;
	logic  cpu_write;
	logic  cpu_ready;
	addr_t cpu_addr;
	word_t cpu_wdata;
	logic  resp_valid;
	word_t resp_data;
	logic  mem_req_valid;
	logic  mem_req_write;
	logic  mem_req_ready;
	addr_t mem_addr;
	word_t mem_wdata;
	logic  mem_rdata_valid;
	word_t mem_rdata;

	word_t shadow [MEM_WORDS];      // expected memory contents
	logic  ref_valid [NUM_BLOCKS];  // expected residency per block
	tag_t  ref_tag [NUM_BLOCKS];

	int    rd_seen = 0;   // memory reads accepted so far
	int    wr_seen = 0;   // memory writes accepted so far
	addr_t wr_addr_seen;  // last write seen on the memory port
	word_t wr_data_seen;

	cache_top dut_i (
		.clk (clk), .rst_n (rst_n),
		.cpu_valid (cpu_valid), .cpu_write (cpu_write), .cpu_ready (cpu_ready),
		.cpu_addr (cpu_addr), .cpu_wdata (cpu_wdata),
		.resp_valid (resp_valid), .resp_data (resp_data),
		.mem_req_valid (mem_req_valid), .mem_req_write (mem_req_write),
		.mem_req_ready (mem_req_ready), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
		.mem_rdata_valid (mem_rdata_valid), .mem_rdata (mem_rdata)
	);

	cache_tb_mem mem_i (
		.clk (clk),
		.mem_req_valid (mem_req_valid), .mem_req_ready (mem_req_ready),
		.mem_req_write (mem_req_write), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
		.mem_rdata_valid (mem_rdata_valid), .mem_rdata (mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// memory port monitor that takes the handshake at the rising edge like the cache does
	always @(posedge clk) begin
		if (mem_req_valid && mem_req_ready) begin
			if (mem_req_write) begin
				wr_seen      = wr_seen + 1;
				wr_addr_seen = mem_addr;
				wr_data_seen = mem_wdata;
			end else
				rd_seen = rd_seen + 1;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_data(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_fills(input string name, input int exp, input int act);
		if (act != exp)
			abort_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// expected word and miss by direct-mapped rules on tag 15..11 and index 10..4
	function automatic word_t ref_access(input logic wr, input addr_t addr, input word_t wdata,
	                                     output bit miss);
		index_t      idx;
		tag_t        tag;
		logic [14:0] waddr;

		idx   = addr[10:4];
		tag   = addr[15:11];
		waddr = addr[15:1];
		miss  = !(ref_valid[idx] && ref_tag[idx] == tag);
		ref_valid[idx] = 1'b1;  // reads and writes both allocate
		ref_tag[idx]   = tag;
		if (wr)
			shadow[waddr] = wdata;  // write-through keeps cache equal to memory
		return shadow[waddr];
	endfunction

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < NUM_BLOCKS; i++)
			ref_valid[index_t'(i)] = 1'b0;  // all blocks cold again
		if (cpu_ready !== 1'b1 || resp_valid !== 1'b0 || mem_req_valid !== 1'b0)
			abort_run("cache is not idle after reset");
	endtask

	// one cpu request from handshake to response and all its checks
	task automatic run_req(input string name, input logic wr, input addr_t addr, input word_t wdata);
		word_t exp_data;
		bit    miss;
		int    rd_start;
		int    wr_start;

		exp_data = ref_access(wr, addr, wdata, miss);
		@(negedge clk);
		rd_start  = rd_seen;
		wr_start  = wr_seen;
		cpu_valid = 1'b1;
		cpu_write = wr;
		cpu_addr  = addr;
		cpu_wdata = wdata;
		while (!cpu_ready)
			@(negedge clk);
		@(negedge clk);  // taken on the edge just passed
		cpu_valid = 1'b0;
		while (!resp_valid)
			@(negedge clk);
		if (wr) begin
			check_fills({name, " mem writes"}, 1, wr_seen - wr_start);
			check_data({name, " write addr"}, addr, wr_addr_seen);
			check_data({name, " write data"}, wdata, wr_data_seen);
		end else
			check_data({name, " read data"}, exp_data, resp_data);
		check_fills({name, " mem reads"}, miss ? 8 : 0, rd_seen - rd_start);
	endtask

	// time budget from the request count
	initial begin
		repeat (NUM_REQS * REQ_CYCLES + 2 * RESET_CYCLES) @(posedge clk);
		abort_run("timeout: no response from cache");
	end

	initial begin : main
		word_t w;
		logic  rnd_wr;
		addr_t rnd_addr;

		cpu_valid = 1'b0;
		cpu_write = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		rst_n     = 1'b0;
		void'($urandom(32'h959fe431));
		for (int i = 0; i < MEM_WORDS; i++) begin
			w = word_t'($urandom);
			shadow[15'(i)]    = w;
			mem_i.mem[15'(i)] = w;  // same contents on both sides
		end
		apply_reset();

		run_req("read miss", 1'b0, ADDR_A, '0);
		for (int i = 0; i < WORDS_PER_BLOCK; i++)
			run_req("read hit", 1'b0, {ADDR_A[15:4], offset_t'(i), 1'b0}, '0);

		run_req("write hit", 1'b1, {ADDR_A[15:4], 3'd5, 1'b0}, 16'hbeef);
		run_req("read after write", 1'b0, {ADDR_A[15:4], 3'd5, 1'b0}, '0);

		run_req("write miss", 1'b1, ADDR_B, 16'hc0de);  // fill first and then write
		for (int i = 0; i < WORDS_PER_BLOCK; i++)
			run_req("allocated block", 1'b0, {ADDR_B[15:4], offset_t'(i), 1'b0}, '0);

		repeat (3) begin
			run_req("conflict c", 1'b0, ADDR_C, '0);
			run_req("conflict d", 1'b0, ADDR_D, '0);
		end

		apply_reset();
		run_req("after reset", 1'b0, ADDR_A, '0);

		// few tags over few blocks so hits, misses and evictions all show up
		for (int n = 0; n < NUM_RANDOM; n++) begin
			rnd_wr   = ($urandom_range(2) == 0);
			rnd_addr = {tag_t'($urandom_range(3)), index_t'($urandom_range(15)),
			            offset_t'($urandom_range(7)), 1'b0};
			run_req($sformatf("random %0d", n), rnd_wr, rnd_addr, word_t'($urandom));
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- cache_top.f
common/cache_pkg.sv
common/cache_array_if.sv
cache/cache_tag_array.sv
cache/cache_data_array.sv
cache/cache_ctrl.sv
design/cache_top.sv
testbench/cache_tb_mem.sv
testbench/cache_tb.sv

//--- Makefile
# Verilator build and run of the cache testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module cache_tb \
		-Mdir obj_dir -f cache_top.f

# the run counts as passed only if the pass line shows up in the output
run: compile
	./obj_dir/Vcache_tb | tee /dev/stderr | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
